// File: routerPkg.sv
package routerPkg;

  // Flit layout.
  localparam int FlitWidth = 16;
  localparam int KindWidth = 3;
  localparam int LengthWidth = 12;

  // Inputs in the order Local, North, East, West, South.
  localparam int NumPorts = 5;

  // Flit kind sits in the top bits of every flit.
  typedef enum logic [KindWidth-1:0]
  {
    kindHead = 3'b001,
    kindBody = 3'b010,
    kindTail = 3'b100
  } flitKind;

  // One-hot arbiter state.
  // Bit 0 is idle and bits 1 to 5 follow the port order.
  typedef enum logic [5:0]
  {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbState;

endpackage

// File: flitDecoder.sv
module flitDecoder
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                inValid,
  input  logic [routerPkg::FlitWidth-1:0]     inFlit,
  input  logic                                accepted,
  output logic                                req,
  output logic [routerPkg::LengthWidth-1:0]   holdLimit
);

  routerPkg::flitKind kind;
  logic               isHead;
  logic               transfer;

  // Kind field from the top bits.
  assign kind = routerPkg::flitKind'(inFlit[routerPkg::FlitWidth-1 -: routerPkg::KindWidth]);
  assign isHead = (kind == routerPkg::kindHead);

  assign transfer = inValid && accepted;

  // Request stays up while a flit waits.
  assign req = inValid;

  // Hold limit comes from the latest accepted head flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLimit <= '0;
    end
    else if (transfer && isHead)
    begin
      holdLimit <= inFlit[routerPkg::LengthWidth-1:0];
    end
  end

endmodule

// File: outputArbiter.sv
module outputArbiter
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [routerPkg::NumPorts-1:0]      req,
  input  logic [routerPkg::LengthWidth-1:0]   holdLimitL,
  input  logic [routerPkg::LengthWidth-1:0]   holdLimitN,
  input  logic [routerPkg::LengthWidth-1:0]   holdLimitE,
  input  logic [routerPkg::LengthWidth-1:0]   holdLimitW,
  input  logic [routerPkg::LengthWidth-1:0]   holdLimitS,
  output logic [routerPkg::NumPorts-1:0]      accept,
  output routerPkg::arbState                  state
);

  routerPkg::arbState                 nextState;
  logic [routerPkg::LengthWidth-1:0]  holdCount;
  logic [routerPkg::LengthWidth-1:0]  holderLimit;
  logic                               holderReq;
  logic                               keep;
  int                                 startIdx;

  // First requester found from start, wrapping once round all inputs.
  function automatic routerPkg::arbState pickNext
  (
    input logic [routerPkg::NumPorts-1:0] r,
    input int                             start
  );
    int idx;
    pickNext = routerPkg::stIdle;
    // Walk backwards so the nearest requester is written last.
    for (int off = routerPkg::NumPorts - 1; off >= 0; off--)
    begin
      idx = (start + off) % routerPkg::NumPorts;
      if (r[idx])
      begin
        pickNext = routerPkg::arbState'(6'(1) << (idx + 1));
      end
    end
  endfunction

  // Holder's request, limit and the rotated search start.
  always_comb
  begin
    holderLimit = '0;
    holderReq = 1'b0;
    startIdx = 0;
    case (state)
      routerPkg::stLocal:
      begin
        holderLimit = holdLimitL;
        holderReq = req[0];
        startIdx = 1;
      end
      routerPkg::stNorth:
      begin
        holderLimit = holdLimitN;
        holderReq = req[1];
        startIdx = 2;
      end
      routerPkg::stEast:
      begin
        holderLimit = holdLimitE;
        holderReq = req[2];
        startIdx = 3;
      end
      routerPkg::stWest:
      begin
        holderLimit = holdLimitW;
        holderReq = req[3];
        startIdx = 4;
      end
      routerPkg::stSouth:
      begin
        holderLimit = holdLimitS;
        holderReq = req[4];
        startIdx = 0;
      end
      default:
      begin
        // Idle searches by fixed priority from Local.
        startIdx = 0;
      end
    endcase
  end

  assign keep = holderReq && (holdCount != holderLimit);

  always_comb
  begin
    if (keep)
    begin
      nextState = state;
    end
    else
    begin
      nextState = pickNext(req, startIdx);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= routerPkg::stIdle;
      holdCount <= '0;
    end
    else
    begin
      state <= nextState;
      // Count clears whenever the grant is re-decided.
      if (keep)
      begin
        holdCount <= holdCount + 1'b1;
      end
      else
      begin
        holdCount <= '0;
      end
    end
  end

  assign accept = state[routerPkg::NumPorts:1];

endmodule

// File: flitMux.sv
module flitMux
(
  input  logic                              clk,
  input  logic                              rst,
  input  routerPkg::arbState                state,
  input  logic [routerPkg::NumPorts-1:0]    inValid,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitL,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitN,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitE,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitW,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitS,
  output logic                              outValid,
  output logic [routerPkg::FlitWidth-1:0]   outFlit,
  output routerPkg::arbState                outSrc
);

  logic                             selValid;
  logic [routerPkg::FlitWidth-1:0]  selFlit;

  // Holder's flit and valid.
  always_comb
  begin
    selValid = 1'b0;
    selFlit = '0;
    case (state)
      routerPkg::stLocal:
      begin
        selValid = inValid[0];
        selFlit = inFlitL;
      end
      routerPkg::stNorth:
      begin
        selValid = inValid[1];
        selFlit = inFlitN;
      end
      routerPkg::stEast:
      begin
        selValid = inValid[2];
        selFlit = inFlitE;
      end
      routerPkg::stWest:
      begin
        selValid = inValid[3];
        selFlit = inFlitW;
      end
      routerPkg::stSouth:
      begin
        selValid = inValid[4];
        selFlit = inFlitS;
      end
      default:
      begin
        selValid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outSrc <= routerPkg::stIdle;
    end
    else
    begin
      outValid <= selValid;
      if (selValid)
      begin
        outSrc <= state;
      end
    end
  end

  // Flit word itself.
  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

// File: outputPortTop.sv
module outputPortTop
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic [routerPkg::NumPorts-1:0]    inValid,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitL,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitN,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitE,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitW,
  input  logic [routerPkg::FlitWidth-1:0]   inFlitS,
  output logic [routerPkg::NumPorts-1:0]    accept,
  output logic                              outValid,
  output logic [routerPkg::FlitWidth-1:0]   outFlit,
  output routerPkg::arbState                outSrc
);

  logic [routerPkg::NumPorts-1:0]     req;
  logic [routerPkg::LengthWidth-1:0]  holdLimitL;
  logic [routerPkg::LengthWidth-1:0]  holdLimitN;
  logic [routerPkg::LengthWidth-1:0]  holdLimitE;
  logic [routerPkg::LengthWidth-1:0]  holdLimitW;
  logic [routerPkg::LengthWidth-1:0]  holdLimitS;
  routerPkg::arbState                 state;

  // Decode stage, one per input.
  flitDecoder decL
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid[0]),
    .inFlit    (inFlitL),
    .accepted  (accept[0]),
    .req       (req[0]),
    .holdLimit (holdLimitL)
  );

  flitDecoder decN
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid[1]),
    .inFlit    (inFlitN),
    .accepted  (accept[1]),
    .req       (req[1]),
    .holdLimit (holdLimitN)
  );

  flitDecoder decE
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid[2]),
    .inFlit    (inFlitE),
    .accepted  (accept[2]),
    .req       (req[2]),
    .holdLimit (holdLimitE)
  );

  flitDecoder decW
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid[3]),
    .inFlit    (inFlitW),
    .accepted  (accept[3]),
    .req       (req[3]),
    .holdLimit (holdLimitW)
  );

  flitDecoder decS
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid[4]),
    .inFlit    (inFlitS),
    .accepted  (accept[4]),
    .req       (req[4]),
    .holdLimit (holdLimitS)
  );

  outputArbiter arb
  (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .holdLimitL (holdLimitL),
    .holdLimitN (holdLimitN),
    .holdLimitE (holdLimitE),
    .holdLimitW (holdLimitW),
    .holdLimitS (holdLimitS),
    .accept     (accept),
    .state      (state)
  );

  flitMux mux
  (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .inValid  (inValid),
    .inFlitL  (inFlitL),
    .inFlitN  (inFlitN),
    .inFlitE  (inFlitE),
    .inFlitW  (inFlitW),
    .inFlitS  (inFlitS),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

endmodule

// File: outputPortTb.sv
module outputPortTb;

  localparam int ResetCycles = 20;
  localparam int DirectedCycles = 400;
  localparam int RandomCycles = 2000;
  localparam int TotalCycles = ResetCycles + DirectedCycles + RandomCycles;
  localparam int WaitLimit = 40;

  logic                                clk = 1'b0;
  logic                                rst;
  logic [routerPkg::NumPorts-1:0]      inValid;
  logic [routerPkg::FlitWidth-1:0]     inFlit [routerPkg::NumPorts];
  logic [routerPkg::NumPorts-1:0]      accept;
  logic                                outValid;
  logic [routerPkg::FlitWidth-1:0]     outFlit;
  routerPkg::arbState                  outSrc;

  // Reference model. Holder -1 means idle.
  int                                  mHolder;
  int                                  mCount;
  logic [routerPkg::LengthWidth-1:0]   mLimit [routerPkg::NumPorts];
  logic                                mOutValid;
  logic [routerPkg::FlitWidth-1:0]     mOutFlit;
  routerPkg::arbState                  mOutSrc;

  logic [routerPkg::NumPorts-1:0]      lastXfer;
  int                                  remain [routerPkg::NumPorts];
  int                                  idleLeft [routerPkg::NumPorts];
  int unsigned                         lcgState = 79;
  int                                  errorCount = 0;
  int                                  testsRun = 0;
  int                                  testsBad = 0;

  outputPortTop UUT
  (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlitL  (inFlit[0]),
    .inFlitN  (inFlit[1]),
    .inFlitE  (inFlit[2]),
    .inFlitW  (inFlit[3]),
    .inFlitS  (inFlit[4]),
    .accept   (accept),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

  always #5 clk = ~clk;

  initial
  begin
    #(TotalCycles * 10 + 200);
    $display("Watchdog timeout, the run did not finish in time.");
    $display("tests failed");
    $finish;
  end

  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  function automatic logic [routerPkg::FlitWidth-1:0] makeFlit(routerPkg::flitKind k, int low);
    return {k, (routerPkg::FlitWidth - routerPkg::KindWidth)'(low)};
  endfunction

  function automatic routerPkg::arbState stateOfHolder(input int h);
    case (h)
      0: return routerPkg::stLocal;
      1: return routerPkg::stNorth;
      2: return routerPkg::stEast;
      3: return routerPkg::stWest;
      4: return routerPkg::stSouth;
      default: return routerPkg::stIdle;
    endcase
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    errorCount++;
  endtask

  // One clock. The model follows the edge, outputs are compared at the falling edge.
  task automatic tick();
    logic [routerPkg::NumPorts-1:0] expAccept;
    logic                           keep;
    int                             pick;
    int                             idx;
    lastXfer = inValid & accept;
    @(negedge clk);
    if (rst)
    begin
      mHolder = -1;
      mCount = 0;
      mOutValid = 1'b0;
      mOutSrc = routerPkg::stIdle;
      for (int i = 0; i < routerPkg::NumPorts; i++)
        mLimit[i] = '0;
    end
    else
    begin
      keep = 1'b0;
      mOutValid = 1'b0;
      if (mHolder >= 0)
      begin
        mOutValid = inValid[mHolder];
        keep = inValid[mHolder] && (mCount != int'(mLimit[mHolder]));
        if (mOutValid)
        begin
          mOutFlit = inFlit[mHolder];
          mOutSrc = stateOfHolder(mHolder);
          if (inFlit[mHolder][routerPkg::FlitWidth-1 -: routerPkg::KindWidth]
              == routerPkg::kindHead)
            mLimit[mHolder] = inFlit[mHolder][routerPkg::LengthWidth-1:0];
        end
      end
      if (keep)
        mCount++;
      else
      begin
        // Search starts after the holder and ends on it; from idle at Local.
        pick = -1;
        for (int k = 1; k <= routerPkg::NumPorts; k++)
        begin
          idx = (mHolder + k) % routerPkg::NumPorts;
          if (pick < 0 && inValid[idx])
            pick = idx;
        end
        mHolder = pick;
        mCount = 0;
      end
    end
    expAccept = '0;
    if (mHolder >= 0)
      expAccept[mHolder] = 1'b1;
    if (accept !== expAccept)
      mismatch("accept", 32'(accept), 32'(expAccept));
    if (outValid !== mOutValid)
      mismatch("outValid", 32'(outValid), 32'(mOutValid));
    if (mOutValid && outFlit !== mOutFlit)
      mismatch("outFlit", 32'(outFlit), 32'(mOutFlit));
    if (outSrc !== mOutSrc)
      mismatch("outSrc", 32'(outSrc), 32'(mOutSrc));
  endtask

  task automatic sendFlit(input int port, input logic [routerPkg::FlitWidth-1:0] flit);
    int waited;
    inValid[port] = 1'b1;
    inFlit[port] = flit;
    waited = 0;
    do
    begin
      tick();
      waited++;
    end
    while (!lastXfer[port] && waited < WaitLimit);
    if (!lastXfer[port])
    begin
      $display("Port %0d waited too long for accept.", port);
      errorCount++;
    end
  endtask

  // Pending flits go out, then each port drops.
  task automatic drainPorts(input logic [routerPkg::NumPorts-1:0] mask);
    int waited;
    waited = 0;
    while ((inValid & mask) != '0 && waited < WaitLimit)
    begin
      tick();
      waited++;
      inValid = inValid & ~(lastXfer & mask);
    end
    if ((inValid & mask) != '0)
    begin
      $display("Pending flits were never accepted while draining.");
      errorCount++;
      inValid = '0;
    end
  endtask

  task automatic updateSource(input int i);
    routerPkg::flitKind kind;
    if (lastXfer[i])
    begin
      if (remain[i] == 0)
      begin
        inValid[i] = 1'b0;
        idleLeft[i] = int'(nextRandom() % 6);
      end
      else
      begin
        remain[i]--;
        kind = (remain[i] == 0) ? routerPkg::kindTail : routerPkg::kindBody;
        inFlit[i] = makeFlit(kind, int'(nextRandom()));
      end
    end
    else if (!inValid[i] && idleLeft[i] > 0)
      idleLeft[i]--;
    else if (!inValid[i])
    begin
      inFlit[i] = makeFlit(routerPkg::kindHead, int'(nextRandom() % 8));
      remain[i] = int'(nextRandom() % 4) + 1;
      inValid[i] = 1'b1;
    end
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testsRun++;
    if (errorCount == startErrors)
      $display("Test %0d %s: ok", testsRun, name);
    else
    begin
      testsBad++;
      $display("Test %0d %s: %0d errors", testsRun, name, errorCount - startErrors);
    end
  endtask

  initial
  begin
    int                              startErrors;
    int                              len;
    int                              held;
    logic [routerPkg::FlitWidth-1:0] pkt [4];
    rst = 1'b1;
    // Every input requests through reset.
    inValid = '1;
    for (int i = 0; i < routerPkg::NumPorts; i++)
      inFlit[i] = makeFlit(routerPkg::kindHead, i + 1);

    startErrors = errorCount;
    for (int c = 0; c < 17; c++)
    begin
      if (c == 16)
      begin
        rst = 1'b0;
        inValid = '0;
      end
      tick();
      if (accept !== '0)
        mismatch("accept", 32'(accept), 32'(0));
      if (outValid !== 1'b0)
        mismatch("outValid", 32'(outValid), 32'(0));
    end
    finishTest("reset", startErrors);

    startErrors = errorCount;
    pkt[0] = makeFlit(routerPkg::kindHead, 2);
    pkt[1] = makeFlit(routerPkg::kindBody, 'h0abc);
    pkt[2] = makeFlit(routerPkg::kindBody, 'h1234);
    pkt[3] = makeFlit(routerPkg::kindTail, 'h0f0f);
    foreach (pkt[f])
    begin
      sendFlit(1, pkt[f]);
      if (outValid !== 1'b1)
        mismatch("outValid", 32'(outValid), 32'(1));
      if (outFlit !== pkt[f])
        mismatch("outFlit", 32'(outFlit), 32'(pkt[f]));
      if (outSrc !== routerPkg::stNorth)
        mismatch("outSrc", 32'(outSrc), 32'(routerPkg::stNorth));
    end
    inValid[1] = 1'b0;
    tick();
    finishTest("single source", startErrors);

    startErrors = errorCount;
    for (int i = 0; i < routerPkg::NumPorts; i++)
      inFlit[i] = makeFlit(routerPkg::kindHead, 1);
    inValid = '1;
    tick();
    if (accept !== 5'b00001)
      mismatch("accept", 32'(accept), 32'(5'b00001));
    drainPorts('1);
    finishTest("fixed priority", startErrors);

    // East holds, then drops with Local, West and South waiting.
    startErrors = errorCount;
    sendFlit(2, makeFlit(routerPkg::kindHead, 5));
    inFlit[0] = makeFlit(routerPkg::kindHead, 0);
    inFlit[3] = makeFlit(routerPkg::kindHead, 0);
    inFlit[4] = makeFlit(routerPkg::kindHead, 0);
    inValid = inValid | 5'b11001;
    sendFlit(2, makeFlit(routerPkg::kindBody, 7));
    sendFlit(2, makeFlit(routerPkg::kindTail, 8));
    inValid[2] = 1'b0;
    tick();
    if (accept !== 5'b01000)
      mismatch("accept", 32'(accept), 32'(5'b01000));
    drainPorts(5'b11001);
    finishTest("rotation", startErrors);

    startErrors = errorCount;
    len = int'(nextRandom() % 8);
    sendFlit(0, makeFlit(routerPkg::kindHead, len));
    inValid[0] = 1'b0;
    repeat (2) tick();
    inFlit[0] = makeFlit(routerPkg::kindBody, 3);
    inFlit[1] = makeFlit(routerPkg::kindHead, 0);
    inValid[1:0] = 2'b11;
    tick();
    held = 0;
    while (accept[0] && held < WaitLimit)
    begin
      held++;
      tick();
    end
    if (held != len + 1)
      mismatch("accept[0] cycles", 32'(held), 32'(len + 1));
    if (accept !== 5'b00010)
      mismatch("accept", 32'(accept), 32'(5'b00010));
    drainPorts(5'b00011);
    finishTest("hold limit", startErrors);

    startErrors = errorCount;
    for (int i = 0; i < routerPkg::NumPorts; i++)
    begin
      remain[i] = 0;
      idleLeft[i] = int'(nextRandom() % 4);
    end
    repeat (RandomCycles)
    begin
      tick();
      for (int i = 0; i < routerPkg::NumPorts; i++)
        updateSource(i);
    end
    finishTest("random traffic", startErrors);

    $display("Summary: %0d tests, %0d with errors, %0d failed checks",
      testsRun, testsBad, errorCount);
    if (errorCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: sources.f
routerPkg.sv
flitDecoder.sv
outputArbiter.sv
flitMux.sv
outputPortTop.sv
outputPortTb.sv

// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
verilator --binary --timing -Wno-fatal --top-module outputPortTb -f sources.f \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/VoutputPortTb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
